// ==== filelist.f ====
+incdir+verification
hdl/guitar_pkg.sv
hdl/ui_pkg.sv
hdl/recorder_control.sv
hdl/beat_timer.sv
hdl/note_capture.sv
hdl/note_memory.sv
hdl/note_display.sv
hdl/recorder_top.sv
verification/tb_recorder.sv

// ==== hdl/beat_timer.sv ====
// Tempo beat counter that opens a capture window once per beat
`timescale 1ns/10ps
`default_nettype none

module beat_timer #(
	parameter int unsigned CLK_HZ       = 50_000_000,
	parameter int unsigned GUARD_CYCLES = 10_000
) (
	input  logic           clk,
	input  logic           resetn,
	input  ui_pkg::speed_t speed,
	output logic           window,
	output logic           window_start,
	output logic           window_end
);

	// slowest tempo sets the counter width
	localparam int unsigned SLOW_PERIOD =
		int'(64'(CLK_HZ) * 64'd60 / 64'(ui_pkg::TEMPO_BPM[0]));
	localparam int CNT_W = $clog2(SLOW_PERIOD);

	logic [CNT_W-1:0] reload [8];
	logic [CNT_W-1:0] count;
	logic             in_window;

	// reload value P-1 per tempo code
	for (genvar i = 0; i < 8; i++) begin : g_reload
		assign reload[i] =
			CNT_W'(64'(CLK_HZ) * 64'd60 / 64'(ui_pkg::TEMPO_BPM[i]) - 64'd1);
	end

	// guard gap is the last GUARD_CYCLES counts of each beat
	assign in_window = (count >= GUARD_CYCLES);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			count        <= reload[speed];
			window       <= 1'b0;
			window_start <= 1'b0;
			window_end   <= 1'b0;
		end else begin
			if (count == '0) begin
				count <= reload[speed];
			end else begin
				count <= count - 1'b1;
			end
			window       <= in_window;
			window_start <= in_window & ~window;
			window_end   <= ~in_window & window;
		end
	end

	assert property (@(posedge clk) disable iff (!resetn)
		!(window_start && window_end))
		else $error("window edges coincide");

endmodule

`default_nettype wire

// ==== hdl/guitar_pkg.sv ====
// Note domain definitions shared by the capture, storage and display datapath
`default_nettype none

package guitar_pkg;

	// guitar geometry
	localparam int NUM_STRINGS   = 6;
	// row 0 is the open row, rows 1 to 4 are the fret bars
	localparam int NUM_FRET_ROWS = 5;

	// storage widths
	localparam int NOTE_W = 32;
	localparam int ADDR_W = 6;

	// one bit per string
	typedef logic [NUM_STRINGS-1:0] string_t;

	// frets 1 to 4 at bits 1 to 4, bit 0 unused
	typedef logic [NUM_FRET_ROWS-1:0] fret_t;

	// bit 6*row + string set when that string sounded on that row
	// bits 30 and 31 stay zero
	typedef logic [NOTE_W-1:0] note_t;

	typedef logic [ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire

// ==== hdl/note_capture.sv ====
// Per-beat string and fret accumulator with string by row note encoding
`timescale 1ns/10ps
`default_nettype none

module note_capture (
	input  logic                clk,
	input  logic                resetn,
	input  logic                window,
	input  guitar_pkg::string_t strings,
	input  guitar_pkg::fret_t   frets,
	output guitar_pkg::note_t   captured_note
);

	localparam int ROW_W = $clog2(guitar_pkg::NUM_FRET_ROWS);

	guitar_pkg::string_t                   string_acc;
	logic [guitar_pkg::NUM_FRET_ROWS-1:0] row_acc;
	logic [ROW_W-1:0]                      row_sel;

	// highest held fret wins, open row when none
	always_comb begin
		row_sel = '0;
		for (int f = 1; f < guitar_pkg::NUM_FRET_ROWS; f++) begin
			if (frets[f]) row_sel = ROW_W'(f);
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn || !window) begin
			string_acc <= '0;
			row_acc    <= '0;
		end else begin
			string_acc       <= string_acc | strings;
			row_acc[row_sel] <= 1'b1;
		end
	end

	// cross strings with rows, top two bits left at zero
	always_comb begin
		captured_note = '0;
		for (int r = 0; r < guitar_pkg::NUM_FRET_ROWS; r++) begin
			captured_note[r*guitar_pkg::NUM_STRINGS +: guitar_pkg::NUM_STRINGS] =
				string_acc & {guitar_pkg::NUM_STRINGS{row_acc[r]}};
		end
	end

endmodule

`default_nettype wire

// ==== hdl/note_display.sv ====
// Two digit seven-segment view of the one-hot index in each note half
`timescale 1ns/10ps
`default_nettype none

module note_display (
	input  guitar_pkg::note_t note,
	output ui_pkg::seg_t      hex_low,
	output ui_pkg::seg_t      hex_high
);

	localparam int HALF_W = guitar_pkg::NOTE_W / 2;

	// index of the single set bit, F otherwise
	function automatic ui_pkg::hex_t onehot_digit(input logic [HALF_W-1:0] half);
		ui_pkg::hex_t idx;
		int           hits;
		idx  = 4'hf;
		hits = 0;
		for (int i = 0; i < HALF_W; i++) begin
			if (half[i]) begin
				idx  = ui_pkg::hex_t'(i);
				hits = hits + 1;
			end
		end
		if (hits != 1) idx = 4'hf;
		return idx;
	endfunction

	// standard active-low patterns
	function automatic ui_pkg::seg_t seg_of(input ui_pkg::hex_t digit);
		case (digit)
			4'h0: return 7'b1000000;
			4'h1: return 7'b1111001;
			4'h2: return 7'b0100100;
			4'h3: return 7'b0110000;
			4'h4: return 7'b0011001;
			4'h5: return 7'b0010010;
			4'h6: return 7'b0000010;
			4'h7: return 7'b1111000;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0011000;
			4'ha: return 7'b0001000;
			4'hb: return 7'b0000011;
			4'hc: return 7'b1000110;
			4'hd: return 7'b0100001;
			4'he: return 7'b0000110;
			default: return 7'b0001110;
		endcase
	endfunction

	assign hex_low  = seg_of(onehot_digit(note[HALF_W-1:0]));
	assign hex_high = seg_of(onehot_digit(note[guitar_pkg::NOTE_W-1:HALF_W]));

endmodule

`default_nettype wire

// ==== hdl/note_memory.sv ====
// Beat address counter and note store with mode gated read out
`timescale 1ns/10ps
`default_nettype none

module note_memory #(
	parameter int DEPTH = 64
) (
	input  logic              clk,
	input  logic              resetn,
	input  logic              window_start,
	input  logic              window_end,
	input  logic              address_clear,
	input  logic              recording,
	input  logic              playing,
	input  guitar_pkg::note_t captured_note,
	output guitar_pkg::addr_t address,
	output guitar_pkg::note_t note
);

	guitar_pkg::note_t mem [DEPTH];

	// one step per beat, wrapping at DEPTH
	always_ff @(posedge clk) begin
		if (!resetn) begin
			address <= '0;
		end else if (window_start) begin
			if (address_clear || address == guitar_pkg::addr_t'(DEPTH - 1)) begin
				address <= '0;
			end else begin
				address <= address + 1'b1;
			end
		end
	end

	// store the finished window
	always_ff @(posedge clk) begin
		if (window_end && recording) begin
			mem[address] <= captured_note;
		end
	end

	assign note = (recording || playing) ? mem[address] : '0;

	assert property (@(posedge clk) disable iff (!resetn)
		!(recording && playing))
		else $error("record and play active together");

endmodule

`default_nettype wire

// ==== hdl/recorder_control.sv ====
// Mode FSM that sequences selection, recording and playback from the buttons
`timescale 1ns/10ps
`default_nettype none

module recorder_control (
	input  logic          clk,
	input  logic          resetn,
	input  logic          select,
	input  logic          back,
	input  ui_pkg::mode_t mode,
	output logic          address_clear,
	output logic          recording,
	output logic          playing
);

	ui_pkg::ctrl_state_t state;
	ui_pkg::ctrl_state_t state_next;

	logic clear_next;
	logic record_next;
	logic play_next;

	//////////////////////////////////////////////////
	// next state
	//////////////////////////////////////////////////
	always_comb begin
		state_next = state;
		case (state)
			ui_pkg::BEGIN:
				state_next = ui_pkg::SELECT_MODE;
			ui_pkg::SELECT_MODE:
				if (select) state_next = ui_pkg::SELECT_MODE_WAIT;
			ui_pkg::SELECT_MODE_WAIT:
				if (!select) state_next = ui_pkg::MODE_CONFIRM;
			ui_pkg::MODE_CONFIRM: begin
				// unknown mode codes stay here
				if (!select && mode == ui_pkg::MODE_PLAY) begin
					state_next = ui_pkg::WAIT_PLAY;
				end else if (!select && mode == ui_pkg::MODE_RECORD) begin
					state_next = ui_pkg::WAIT_RECORD;
				end
			end

			// record branch
			ui_pkg::WAIT_RECORD: begin
				if (back) begin
					state_next = ui_pkg::SELECT_MODE;
				end else if (select) begin
					state_next = ui_pkg::WAIT_RECORD_WAIT;
				end
			end
			ui_pkg::WAIT_RECORD_WAIT:
				if (!select) state_next = ui_pkg::RECORDING;
			ui_pkg::RECORDING:
				if (select) state_next = ui_pkg::RECORDING_WAIT;
			ui_pkg::RECORDING_WAIT:
				if (!select) state_next = ui_pkg::RECORD_STOP;
			ui_pkg::RECORD_STOP:
				if (select || back) state_next = ui_pkg::RECORD_STOP_WAIT;
			ui_pkg::RECORD_STOP_WAIT:
				if (!select) state_next = ui_pkg::END;

			// play branch
			ui_pkg::WAIT_PLAY: begin
				if (back) begin
					state_next = ui_pkg::SELECT_MODE;
				end else if (select) begin
					state_next = ui_pkg::WAIT_PLAY_WAIT;
				end
			end
			ui_pkg::WAIT_PLAY_WAIT:
				if (!select) state_next = ui_pkg::PLAYING;
			ui_pkg::PLAYING:
				if (select) state_next = ui_pkg::PLAYING_WAIT;
			ui_pkg::PLAYING_WAIT:
				if (!select) state_next = ui_pkg::PLAY_STOP;
			ui_pkg::PLAY_STOP:
				if (select || back) state_next = ui_pkg::PLAY_STOP_WAIT;
			ui_pkg::PLAY_STOP_WAIT:
				if (!select) state_next = ui_pkg::END;

			ui_pkg::END:
				state_next = ui_pkg::BEGIN;
			default:
				state_next = ui_pkg::BEGIN;
		endcase
	end

	// levels decoded from the upcoming state, so they track the state register
	always_comb begin
		clear_next  = 1'b0;
		record_next = 1'b0;
		play_next   = 1'b0;
		case (state_next)
			ui_pkg::WAIT_RECORD, ui_pkg::WAIT_RECORD_WAIT,
			ui_pkg::WAIT_PLAY, ui_pkg::WAIT_PLAY_WAIT:
				clear_next = 1'b1;
			ui_pkg::RECORDING, ui_pkg::RECORDING_WAIT:
				record_next = 1'b1;
			ui_pkg::PLAYING, ui_pkg::PLAYING_WAIT:
				play_next = 1'b1;
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state         <= ui_pkg::BEGIN;
			address_clear <= 1'b0;
			recording     <= 1'b0;
			playing       <= 1'b0;
		end else begin
			state         <= state_next;
			address_clear <= clear_next;
			recording     <= record_next;
			playing       <= play_next;
		end
	end

	// the datapath relies on one mode at a time
	assert property (@(posedge clk) disable iff (!resetn)
		$onehot0({address_clear, recording, playing}))
		else $error("controller levels overlap");

endmodule

`default_nettype wire

// ==== hdl/recorder_top.sv ====
// Guitar chord step recorder top level joining the controller and note datapath
`timescale 1ns/10ps
`default_nettype none

module recorder_top #(
	parameter int unsigned CLK_HZ       = 50_000_000,
	parameter int unsigned GUARD_CYCLES = 10_000,
	parameter int          DEPTH        = 64
) (
	input  logic               clk,
	input  logic               resetn,
	input  logic               select,
	input  logic               back,
	input  ui_pkg::mode_t      mode,
	input  ui_pkg::speed_t     speed,
	input  guitar_pkg::string_t strings,
	input  guitar_pkg::fret_t  frets,
	output logic               beat_window,
	output guitar_pkg::addr_t  note_address,
	output guitar_pkg::note_t  note,
	output ui_pkg::seg_t       hex_low,
	output ui_pkg::seg_t       hex_high
);

	// controller levels
	logic address_clear;
	logic recording;
	logic playing;

	// beat timing
	logic window;
	logic window_start;
	logic window_end;

	guitar_pkg::note_t captured_note;

	recorder_control u_control (
		.clk          (clk),
		.resetn       (resetn),
		.select       (select),
		.back         (back),
		.mode         (mode),
		.address_clear(address_clear),
		.recording    (recording),
		.playing      (playing)
	);

	beat_timer #(
		.CLK_HZ      (CLK_HZ),
		.GUARD_CYCLES(GUARD_CYCLES)
	) u_beat_timer (
		.clk         (clk),
		.resetn      (resetn),
		.speed       (speed),
		.window      (window),
		.window_start(window_start),
		.window_end  (window_end)
	);

	note_capture u_capture (
		.clk          (clk),
		.resetn       (resetn),
		.window       (window),
		.strings      (strings),
		.frets        (frets),
		.captured_note(captured_note)
	);

	note_memory #(
		.DEPTH(DEPTH)
	) u_memory (
		.clk          (clk),
		.resetn       (resetn),
		.window_start (window_start),
		.window_end   (window_end),
		.address_clear(address_clear),
		.recording    (recording),
		.playing      (playing),
		.captured_note(captured_note),
		.address      (note_address),
		.note         (note)
	);

	note_display u_display (
		.note    (note),
		.hex_low (hex_low),
		.hex_high(hex_high)
	);

	assign beat_window = window;

endmodule

`default_nettype wire

// ==== hdl/ui_pkg.sv ====
// User interface definitions for the controller, tempo selection and display
`default_nettype none

package ui_pkg;

	//////////////////////////////////////////////////
	// controller states
	//////////////////////////////////////////////////
	typedef enum logic [4:0] {
		BEGIN,
		SELECT_MODE,
		SELECT_MODE_WAIT,
		MODE_CONFIRM,
		WAIT_RECORD,
		WAIT_RECORD_WAIT,
		RECORDING,
		RECORDING_WAIT,
		RECORD_STOP,
		RECORD_STOP_WAIT,
		WAIT_PLAY,
		WAIT_PLAY_WAIT,
		PLAYING,
		PLAYING_WAIT,
		PLAY_STOP,
		PLAY_STOP_WAIT,
		END
	} ctrl_state_t;

	//////////////////////////////////////////////////
	// tempo and mode selection
	//////////////////////////////////////////////////
	typedef logic [2:0] speed_t;
	typedef logic [1:0] mode_t;

	localparam mode_t MODE_PLAY   = 2'd0;
	localparam mode_t MODE_RECORD = 2'd1;

	// beats per minute, slowest first
	localparam int unsigned TEMPO_BPM [8] = '{40, 60, 80, 100, 120, 140, 180, 220};

	//////////////////////////////////////////////////
	// display
	//////////////////////////////////////////////////
	typedef logic [3:0] hex_t;
	// segments gfedcba, active low
	typedef logic [6:0] seg_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the recorder testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_recorder -f filelist.f -Mdir obj_dir -o tb_recorder
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_recorder > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "sim passed" sim.log; then
	exit 0
fi
echo "pass line not found in sim.log"
exit 1

// ==== verification/tb_recorder_tasks.svh ====
// Stimulus, compare and directed test tasks for the chord recorder testbench
`ifndef TB_RECORDER_TASKS_SVH
`define TB_RECORDER_TASKS_SVH

//////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////
task automatic fail_now(input string msg);
	fail_count++;
	$display("%s", msg);
	$display("sim failed");
	$fatal(1, "stopping at first error");
endtask

task automatic check_note(input string test, input guitar_pkg::note_t exp,
		input guitar_pkg::note_t act);
	if (act !== exp) fail_now($sformatf("FAIL %s expected %h actual %h", test, exp, act));
endtask

task automatic check_addr(input string test, input guitar_pkg::addr_t exp,
		input guitar_pkg::addr_t act);
	if (act !== exp) fail_now($sformatf("FAIL %s expected %0d actual %0d", test, exp, act));
endtask

task automatic check_seg(input string test, input ui_pkg::seg_t exp, input ui_pkg::seg_t act);
	if (act !== exp) fail_now($sformatf("FAIL %s expected %b actual %b", test, exp, act));
endtask

task automatic check_count(input string test, input int exp, input int act);
	if (act != exp) fail_now($sformatf("FAIL %s expected %0d actual %0d", test, exp, act));
endtask

task automatic check_display(input string test, input guitar_pkg::note_t n);
	check_seg({test, "_low"}, expected_seg(n[15:0]), hex_low);
	check_seg({test, "_high"}, expected_seg(n[31:16]), hex_high);
endtask

//////////////////////////////////////////////////
// stimulus
//////////////////////////////////////////////////
// outputs are sampled on falling edges
task automatic skip_cycles(input int n);
	repeat (n) @(negedge clk);
endtask

task automatic window_rise();
	@(negedge clk);
	while (beat_window) @(negedge clk);
	while (!beat_window) @(negedge clk);
endtask

task automatic window_fall();
	@(negedge clk);
	while (!beat_window) @(negedge clk);
	while (beat_window) @(negedge clk);
endtask

task automatic reach_guard();
	@(negedge clk);
	while (beat_window) @(negedge clk);
endtask

// one cycle press, then time for the FSM to walk its wait states
task automatic press_button(input logic is_back);
	@(posedge clk);
	if (is_back) back <= 1'b1;
	else select <= 1'b1;
	@(posedge clk);
	back   <= 1'b0;
	select <= 1'b0;
	skip_cycles(4);
endtask

task automatic drive_chord(input guitar_pkg::string_t s, input guitar_pkg::fret_t f);
	@(posedge clk);
	strings <= s;
	frets   <= f;
endtask

//////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////
task automatic reset_defaults();
	skip_cycles(1);
	check_note("reset_note", '0, note);
	check_addr("reset_address", '0, note_address);
	check_count("reset_window", 0, int'(beat_window));
	check_seg("reset_hex_low", SEG_TABLE[15], hex_low);
	check_seg("reset_hex_high", SEG_TABLE[15], hex_high);
endtask

task automatic beat_lengths(input ui_pkg::speed_t s);
	int high_len;
	int low_len;
	high_len = 0;
	low_len  = 0;
	@(posedge clk);
	speed <= s;
	// the running beat ends at the old tempo
	window_rise();
	window_rise();
	while (beat_window) begin
		high_len++;
		@(negedge clk);
	end
	while (!beat_window) begin
		low_len++;
		@(negedge clk);
	end
	check_count("beat_high", beat_period(s) - GUARD_CYCLES, high_len);
	check_count("beat_low", GUARD_CYCLES, low_len);
endtask

task automatic record_beats();
	logic [31:0]         r;
	guitar_pkg::string_t s;
	guitar_pkg::fret_t   f;
	guitar_pkg::note_t   exp;
	@(posedge clk);
	mode <= ui_pkg::MODE_RECORD;
	press_button(1'b0);
	check_note("record_armed", '0, note);
	// a window start in WAIT_RECORD clears the address
	window_rise();
	press_button(1'b0);
	reach_guard();
	for (int b = 0; b < 6; b++) begin
		r = rand_next();
		if (b % 2 == 0) s = guitar_pkg::string_t'(6'd1 << (r[18:16] % 3'd6));
		else s = r[21:16];
		f = r[28:24];
		drive_chord(s, f);
		window_rise();
		window_fall();
		skip_cycles(2);
		exp = expected_note(s, f);
		check_note("record", exp, note);
		check_display("record", exp);
		expected_mem[note_address] = exp;
	end
	check_count("record_entries", 6, expected_mem.num());
	drive_chord('0, '0);
	press_button(1'b0);
	press_button(1'b1);
	check_note("record_stopped", '0, note);
endtask

task automatic play_back();
	int hits;
	hits = 0;
	@(posedge clk);
	mode <= ui_pkg::MODE_PLAY;
	press_button(1'b0);
	check_note("play_armed", '0, note);
	window_rise();
	press_button(1'b0);
	for (int b = 0; b < 7; b++) begin
		window_rise();
		// address steps one cycle after the window opens
		skip_cycles(2);
		if (expected_mem.exists(note_address)) begin
			check_note("play", expected_mem[note_address], note);
			check_display("play", expected_mem[note_address]);
			hits++;
		end
	end
	check_count("play_hits", expected_mem.num(), hits);
	press_button(1'b0);
	press_button(1'b1);
	check_note("play_stopped", '0, note);
endtask

task automatic back_to_idle();
	@(posedge clk);
	mode <= ui_pkg::MODE_PLAY;
	press_button(1'b0);
	// a window start in WAIT_PLAY clears the address
	window_rise();
	skip_cycles(2);
	check_addr("idle_clear", '0, note_address);
	press_button(1'b1);
	// unknown mode code parks the FSM in MODE_CONFIRM
	// a stuck WAIT_PLAY would instead play back from address 1
	@(posedge clk);
	mode <= ui_pkg::mode_t'(2);
	press_button(1'b0);
	for (int b = 0; b < 2; b++) begin
		window_rise();
		skip_cycles(2);
		check_note("idle_window", '0, note);
		check_display("idle_window", '0);
		window_fall();
		skip_cycles(2);
		check_note("idle_gap", '0, note);
	end
endtask

`endif

// ==== verification/tb_recorder.sv ====
// Testbench for the guitar chord step recorder with beat, record, play and display checks
`timescale 1ns/10ps
`default_nettype none

module tb_recorder;

	localparam int unsigned CLK_HZ       = 440;
	localparam int unsigned GUARD_CYCLES = 16;
	localparam int          DEPTH        = 64;
	localparam int          CLK_PERIOD   = 8;

	// beats spent by the whole sequence, with margin
	localparam int SLOW_BEATS  = 4;
	localparam int FAST_BEATS  = 30;
	localparam int SLOW_PERIOD = int'(CLK_HZ * 60 / ui_pkg::TEMPO_BPM[0]);
	localparam int FAST_PERIOD = int'(CLK_HZ * 60 / ui_pkg::TEMPO_BPM[7]);
	localparam int WATCHDOG_NS =
		(SLOW_BEATS * SLOW_PERIOD + FAST_BEATS * FAST_PERIOD) * 2 * CLK_PERIOD;

	// active-low gfedcba patterns for 0 to F
	localparam ui_pkg::seg_t SEG_TABLE [16] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h18, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
	};

	logic                clk;
	logic                resetn;
	logic                select;
	logic                back;
	ui_pkg::mode_t       mode;
	ui_pkg::speed_t      speed;
	guitar_pkg::string_t strings;
	guitar_pkg::fret_t   frets;
	logic                beat_window;
	guitar_pkg::addr_t   note_address;
	guitar_pkg::note_t   note;
	ui_pkg::seg_t        hex_low;
	ui_pkg::seg_t        hex_high;

	logic [31:0] lcg_state;
	int          fail_count;

	// notes written during recording, keyed by beat address
	guitar_pkg::note_t expected_mem [guitar_pkg::addr_t];

	recorder_top #(
		.CLK_HZ      (CLK_HZ),
		.GUARD_CYCLES(GUARD_CYCLES),
		.DEPTH       (DEPTH)
	) UUT (
		.clk         (clk),
		.resetn      (resetn),
		.select      (select),
		.back        (back),
		.mode        (mode),
		.speed       (speed),
		.strings     (strings),
		.frets       (frets),
		.beat_window (beat_window),
		.note_address(note_address),
		.note        (note),
		.hex_low     (hex_low),
		.hex_high    (hex_high)
	);

	`include "tb_recorder_tasks.svh"

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////
	function automatic logic [31:0] rand_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic int beat_period(input ui_pkg::speed_t s);
		return int'(CLK_HZ * 60 / ui_pkg::TEMPO_BPM[s]);
	endfunction

	// struck strings land in the row of the highest held fret
	function automatic guitar_pkg::note_t expected_note(input guitar_pkg::string_t s,
			input guitar_pkg::fret_t f);
		int row;
		row = 0;
		for (int i = 1; i <= 4; i++) begin
			if (f[i]) row = i;
		end
		return guitar_pkg::note_t'(s) << (guitar_pkg::NUM_STRINGS * row);
	endfunction

	function automatic ui_pkg::seg_t expected_seg(input logic [15:0] half);
		if ($countones(half) == 1) begin
			return SEG_TABLE[$clog2(half)];
		end else begin
			return SEG_TABLE[15];
		end
	endfunction

	//////////////////////////////////////////////////
	// clock, watchdog and sequence
	//////////////////////////////////////////////////
	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the test sequence finished");
		$display("sim failed");
		$fatal(1, "timeout");
	end

	initial begin
		resetn     = 1'b0;
		select     = 1'b0;
		back       = 1'b0;
		mode       = ui_pkg::MODE_PLAY;
		speed      = '0;
		strings    = '0;
		frets      = '0;
		lcg_state  = 32'h5352;
		fail_count = 0;
		repeat (2) @(posedge clk);
		resetn <= 1'b1;

		reset_defaults();
		beat_lengths(3'd0);
		beat_lengths(3'd7);
		record_beats();
		play_back();
		back_to_idle();

		if (fail_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
